/* bp_top.f */
+incdir+source
source/bp_pkg.sv
source/bp_ifs.sv
source/bp_lookup.sv
source/bp_inflight_fifo.sv
source/bp_resolve.sv
source/bp_top.sv
testbench/bp_tb.sv

/* run.sh */
#!/bin/sh
# build the predictor testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module bp_tb -f bp_top.f -o bp_sim || exit 1
out=$(./obj_dir/bp_sim)
echo "$out"
echo "$out" | grep -qx "Simulation passed" && exit 0 || exit 1

/* source/bp_ifs.sv */
// handshake record channel and table update channel used between predictor blocks
`timescale 1ns/1ps

// valid/ready record channel, flush travels back from the consumer
interface bp_rec_if import bp_pkg::*; ();

    logic    valid;
    logic    ready;
    logic    flush;
    bp_rec_t rec;

    modport src (
        output valid,
        output rec,
        input  ready,
        input  flush
    );

    modport snk (
        input  valid,
        input  rec,
        output ready,
        output flush
    );

endinterface

// table writes from resolve back to lookup
interface bp_upd_if import bp_pkg::*; ();

    bp_upd_t upd;
    logic    redirect;  // mispredict seen in this cycle

    modport src (
        output upd,
        output redirect
    );

    modport snk (
        input  upd,
        input  redirect
    );

endinterface

/* source/bp_inflight_fifo.sv */
// ordered queue of prediction records between lookup and resolve that a flush empties
`timescale 1ns/1ps
`include "bp_settings.svh"

module bp_inflight_fifo import bp_pkg::*; (
    input  logic  clk,
    input  logic  arst_n_i,
    bp_rec_if.snk push_i,
    bp_rec_if.src pop_o
);

    localparam int depth = `BP_FIFO_DEPTH;
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    bp_rec_t          mem_q [depth];
    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w-1:0] rd_ptr_q;
    logic [cnt_w-1:0] count_q;
    logic             push;
    logic             pop;
    logic             flush;

    assign flush = pop_o.flush;
    assign push  = push_i.valid && push_i.ready;
    assign pop   = pop_o.valid && pop_o.ready;

    assign push_i.ready  = (count_q != cnt_w'(depth));
    assign pop_o.valid   = (count_q != '0);
    assign pop_o.rec     = mem_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_i.rec;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush) begin
            wr_ptr_q <= '0;  // wins over a push in the same cycle
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + cnt_w'(push) - cnt_w'(pop);
        end
    end

endmodule

/* source/bp_lookup.sv */
// BTB and gshare lookup, answers each fetch pc in the same cycle and takes resolve updates
`timescale 1ns/1ps
`include "bp_settings.svh"

module bp_lookup import bp_pkg::*; (
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic        fetch_valid_i,
    input  logic [31:0] fetch_pc_i,
    output logic        fetch_ready_o,
    output logic        pred_taken_o,
    output logic [31:0] pred_target_o,
    bp_rec_if.src       rec_o,
    bp_upd_if.snk       upd_i
);

    localparam int btb_entries = `BP_BTB_ENTRIES;
    localparam int pht_entries = 1 << `BP_GHR_BITS;

    logic [btb_tag_w-1:0] btb_tag_q    [btb_entries];
    logic [31:0]          btb_target_q [btb_entries];
    bp_kind_e             btb_kind_q   [btb_entries];
    logic                 btb_valid_q  [btb_entries];
    logic [1:0]           pht_q        [pht_entries];
    logic [pht_idx_w-1:0] ghr_q;

    logic [btb_idx_w-1:0] btb_idx;
    logic [btb_tag_w-1:0] pc_tag;
    logic [pht_idx_w-1:0] pht_idx;
    logic                 btb_hit;
    bp_kind_e             hit_kind;
    logic [1:0]           ctr;
    logic                 pred_taken;
    logic [31:0]          pred_target;
    bp_upd_t              upd;

    assign upd = upd_i.upd;

    // index and tag from the fetch pc
    assign btb_idx = fetch_pc_i[btb_idx_w+1:2];
    assign pc_tag  = fetch_pc_i[31:btb_idx_w+2];
    assign pht_idx = fetch_pc_i[pht_idx_w+1:2] ^ ghr_q;  // gshare

    assign btb_hit  = btb_valid_q[btb_idx] && (btb_tag_q[btb_idx] == pc_tag);
    assign hit_kind = btb_kind_q[btb_idx];
    assign ctr      = pht_q[pht_idx];

    always_comb begin
        pred_taken  = 1'b0;
        pred_target = 32'd0;
        if (btb_hit) begin
            pred_target = btb_target_q[btb_idx];
            case (hit_kind)
                kind_jal, kind_jalr: pred_taken = 1'b1;
                kind_branch:         pred_taken = ctr[1];
                default:             pred_taken = 1'b0;
            endcase
        end
    end

    assign pred_taken_o  = pred_taken;
    assign pred_target_o = pred_target;
    assign fetch_ready_o = rec_o.ready;

    // a record pushed during a redirect would be flushed anyway
    assign rec_o.valid           = fetch_valid_i && !upd_i.redirect;
    assign rec_o.rec.pc          = fetch_pc_i;
    assign rec_o.rec.pred_taken  = pred_taken;
    assign rec_o.rec.pred_target = pred_target;
    assign rec_o.rec.btb_hit     = btb_hit;
    assign rec_o.rec.pht_idx     = pht_idx;

    // BTB payload, qualified by the valid bits
    always_ff @(posedge clk) begin
        if (upd.btb_we) begin
            btb_tag_q[upd.btb_idx]    <= upd.btb_tag;
            btb_target_q[upd.btb_idx] <= upd.btb_target;
            btb_kind_q[upd.btb_idx]   <= upd.btb_kind;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < btb_entries; i++) begin
                btb_valid_q[i] <= 1'b0;
            end
        end else if (upd.btb_we) begin
            btb_valid_q[upd.btb_idx] <= 1'b1;
        end
    end

    // 2-bit saturating counters, weakly not taken out of reset
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < pht_entries; i++) begin
                pht_q[i] <= 2'b01;
            end
        end else if (upd.pht_we) begin
            if (upd.taken && pht_q[upd.pht_idx] != 2'b11) begin
                pht_q[upd.pht_idx] <= pht_q[upd.pht_idx] + 2'b01;
            end else if (!upd.taken && pht_q[upd.pht_idx] != 2'b00) begin
                pht_q[upd.pht_idx] <= pht_q[upd.pht_idx] - 2'b01;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ghr_q <= '0;
        end else if (upd.ghr_we) begin
            ghr_q <= {ghr_q[pht_idx_w-2:0], upd.taken};  // newest outcome in the lsb
        end
    end

endmodule

/* source/bp_pkg.sv */
// shared predictor types: branch kind, queue record, table update and instruction views
`include "bp_settings.svh"

package bp_pkg;

    localparam int btb_idx_w = $clog2(`BP_BTB_ENTRIES);
    localparam int btb_tag_w = 30 - btb_idx_w;          // pc bits above the index
    localparam int pht_idx_w = `BP_GHR_BITS;

    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;

    typedef enum logic [1:0] {
        kind_none   = 2'd0,
        kind_branch = 2'd1,
        kind_jal    = 2'd2,
        kind_jalr   = 2'd3
    } bp_kind_e;

    // prediction as made at fetch, checked later at resolve
    typedef struct packed {
        logic [31:0]          pc;
        logic                 pred_taken;
        logic [31:0]          pred_target;
        logic                 btb_hit;
        logic [pht_idx_w-1:0] pht_idx;    // gshare index used at lookup
    } bp_rec_t;

    typedef struct packed {
        logic                 btb_we;
        logic [btb_idx_w-1:0] btb_idx;
        logic [btb_tag_w-1:0] btb_tag;
        logic [31:0]          btb_target;
        bp_kind_e             btb_kind;
        logic                 pht_we;
        logic [pht_idx_w-1:0] pht_idx;
        logic                 ghr_we;
        logic                 taken;      // resolved outcome, feeds counter and history
    } bp_upd_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } rv_b_view_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_j_view_t;

    // one instruction word, read as B-type or J-type
    typedef union packed {
        rv_b_view_t b;
        rv_j_view_t j;
    } rv_instr_u;

endpackage

/* source/bp_resolve.sv */
// checks the oldest prediction against the execute outcome, redirects and trains the tables
`timescale 1ns/1ps

module bp_resolve import bp_pkg::*; (
    input  logic        clk,
    input  logic        arst_n_i,
    bp_rec_if.snk       rec_i,
    input  logic        resolve_valid_i,
    input  rv_instr_u   resolve_instr_i,
    input  logic        resolve_taken_i,
    input  logic [31:0] resolve_target_i,
    output logic        resolve_ready_o,
    bp_upd_if.src       upd_o,
    output logic        mispredict_o,
    output logic [31:0] redirect_pc_o
);

    bp_rec_t     head;
    bp_kind_e    kind;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        fire;
    logic        act_taken;
    logic [31:0] act_target;
    logic        mispredict;
    logic [31:0] redirect_pc;
    bp_upd_t     upd;
    logic        mispredict_q;
    logic [31:0] redirect_pc_q;

    assign head            = rec_i.rec;
    assign fire            = rec_i.valid && resolve_valid_i;
    assign rec_i.ready     = resolve_valid_i;
    assign resolve_ready_o = rec_i.valid;  // outcome accepted only against a recorded prediction

    always_comb begin
        case (resolve_instr_i.b.opcode)
            opc_branch: kind = kind_branch;
            opc_jal:    kind = kind_jal;
            opc_jalr:   kind = kind_jalr;
            default:    kind = kind_none;
        endcase
    end

    assign imm_b = {{20{resolve_instr_i.b.imm12}}, resolve_instr_i.b.imm11,
                    resolve_instr_i.b.imm10_5, resolve_instr_i.b.imm4_1, 1'b0};
    assign imm_j = {{12{resolve_instr_i.j.imm20}}, resolve_instr_i.j.imm19_12,
                    resolve_instr_i.j.imm11, resolve_instr_i.j.imm10_1, 1'b0};

    always_comb begin
        act_taken  = 1'b0;
        act_target = head.pc + 32'd4;
        case (kind)
            kind_branch: begin
                act_taken  = resolve_taken_i;
                act_target = head.pc + imm_b;
            end
            kind_jal: begin
                act_taken  = 1'b1;
                act_target = head.pc + imm_j;
            end
            kind_jalr: begin
                act_taken  = 1'b1;
                act_target = resolve_target_i;  // register based, only execute knows
            end
            default: ;
        endcase
    end

    assign mispredict  = (act_taken != head.pred_taken) ||
                         (act_taken && act_target != head.pred_target);
    assign redirect_pc = act_taken ? act_target : head.pc + 32'd4;

    always_comb begin
        upd            = '0;
        upd.btb_we     = fire && (kind != kind_none);
        upd.btb_idx    = head.pc[btb_idx_w+1:2];
        upd.btb_tag    = head.pc[31:btb_idx_w+2];
        upd.btb_target = act_target;
        upd.btb_kind   = kind;
        upd.pht_we     = fire && (kind == kind_branch);
        upd.pht_idx    = head.pht_idx;
        upd.ghr_we     = fire && (kind == kind_branch);
        upd.taken      = act_taken;
    end

    assign upd_o.upd      = upd;
    assign upd_o.redirect = fire && mispredict;
    assign rec_i.flush    = fire && mispredict;  // younger records follow the wrong path

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mispredict_q <= 1'b0;
        end else begin
            mispredict_q <= fire && mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            redirect_pc_q <= redirect_pc;
        end
    end

    assign mispredict_o  = mispredict_q;
    assign redirect_pc_o = redirect_pc_q;

endmodule

/* source/bp_settings.svh */
// predictor sizing macros, included by the package, the RTL blocks and the testbench
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// BTB entries, indexed by pc[idx+1:2]
`define BP_BTB_ENTRIES 32

// global history width, the pattern table holds 2**BP_GHR_BITS counters
`define BP_GHR_BITS 5

// records awaiting resolution
`define BP_FIFO_DEPTH 4

`endif

/* source/bp_top.sv */
// branch predictor top level, connects lookup, in-flight queue and resolve through interfaces
`timescale 1ns/1ps

module bp_top (
    input  logic        clk,
    input  logic        arst_n_i,
    // fetch side
    input  logic        fetch_valid_i,
    input  logic [31:0] fetch_pc_i,
    output logic        fetch_ready_o,
    output logic        pred_taken_o,
    output logic [31:0] pred_target_o,
    // execute side
    input  logic        resolve_valid_i,
    input  logic [31:0] resolve_instr_i,
    input  logic        resolve_taken_i,
    input  logic [31:0] resolve_target_i,
    output logic        resolve_ready_o,
    // redirect
    output logic        mispredict_o,
    output logic [31:0] redirect_pc_o
);

    bp_rec_if push_if ();   // lookup to queue
    bp_rec_if head_if ();   // queue to resolve
    bp_upd_if upd_if ();

    bp_lookup i_bp_lookup (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_pc_i    (fetch_pc_i),
        .fetch_ready_o (fetch_ready_o),
        .pred_taken_o  (pred_taken_o),
        .pred_target_o (pred_target_o),
        .rec_o         (push_if.src),
        .upd_i         (upd_if.snk)
    );

    bp_inflight_fifo i_bp_inflight_fifo (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .push_i   (push_if.snk),
        .pop_o    (head_if.src)
    );

    bp_resolve i_bp_resolve (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .rec_i            (head_if.snk),
        .resolve_valid_i  (resolve_valid_i),
        .resolve_instr_i  (resolve_instr_i),
        .resolve_taken_i  (resolve_taken_i),
        .resolve_target_i (resolve_target_i),
        .resolve_ready_o  (resolve_ready_o),
        .upd_o            (upd_if.src),
        .mispredict_o     (mispredict_o),
        .redirect_pc_o    (redirect_pc_o)
    );

endmodule

/* testbench/bp_tb.sv */
// testbench for the branch predictor top level: directed and random tests against a reference model
`timescale 1ns/1ps
`include "bp_settings.svh"

module bp_tb import bp_pkg::*; ();

    localparam int depth         = `BP_FIFO_DEPTH;
    localparam int bidx_w        = $clog2(`BP_BTB_ENTRIES);
    localparam int gw            = `BP_GHR_BITS;
    localparam int n_rand        = 400;
    localparam int hs_limit      = 50;
    localparam int total_cycles  = 8 + 250 + n_rand + 100;
    localparam int watchdog_ns   = total_cycles * 4 * 2;
    localparam logic [31:0] instr_addi = 32'h0010_0093;
    localparam logic [31:0] instr_jalr = {12'd0, 5'd1, 3'b000, 5'd1, opc_jalr};

    logic        clk;
    logic        arst_n_i;
    logic        fetch_valid_i;
    logic [31:0] fetch_pc_i;
    logic        fetch_ready_o;
    logic        pred_taken_o;
    logic [31:0] pred_target_o;
    logic        resolve_valid_i;
    logic [31:0] resolve_instr_i;
    logic        resolve_taken_i;
    logic [31:0] resolve_target_i;
    logic        resolve_ready_o;
    logic        mispredict_o;
    logic [31:0] redirect_pc_o;

    // reference model state
    logic [31:0] m_pc   [`BP_BTB_ENTRIES];
    logic [31:0] m_tgt  [`BP_BTB_ENTRIES];
    bp_kind_e    m_kind [`BP_BTB_ENTRIES];
    logic        m_val  [`BP_BTB_ENTRIES];
    logic [1:0]  m_pht  [1 << gw];
    logic [gw-1:0] m_ghr;
    bp_rec_t     mq [$];  // in-flight records as the model sees them

    logic        exp_mis;
    logic [31:0] exp_redir;
    logic        redir_known;
    logic        fetch_hs;
    logic        res_hs;
    logic        hs_taken;
    logic [31:0] hs_target;
    logic        fetch_done;
    string       test_name;
    int          test_err;
    int          test_count;
    int          check_count;
    int          err_count;

    bp_top i_bp_top (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_pc_i       (fetch_pc_i),
        .fetch_ready_o    (fetch_ready_o),
        .pred_taken_o     (pred_taken_o),
        .pred_target_o    (pred_target_o),
        .resolve_valid_i  (resolve_valid_i),
        .resolve_instr_i  (resolve_instr_i),
        .resolve_taken_i  (resolve_taken_i),
        .resolve_target_i (resolve_target_i),
        .resolve_ready_o  (resolve_ready_o),
        .mispredict_o     (mispredict_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] enc_b(input logic [31:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] enc_j(input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, opc_jal};
    endfunction

    // fixed program image for the random stream, one instruction per pc
    function automatic logic [31:0] program_instr(input logic [31:0] pc);
        case (pc[3:2] ^ pc[6:5])
            2'd0:    return instr_addi;
            2'd1:    return enc_b(32'($signed({pc[4], pc[9:5], 3'b000})));
            2'd2:    return enc_j(32'($signed({pc[5], pc[10:6], 4'b0000})));
            default: return instr_jalr;
        endcase
    endfunction

    function automatic bp_rec_t predict_ref(input logic [31:0] pc);
        bp_rec_t           r;
        logic [bidx_w-1:0] idx;
        idx       = pc[bidx_w+1:2];
        r         = '0;
        r.pc      = pc;
        r.pht_idx = pc[gw+1:2] ^ m_ghr;
        r.btb_hit = m_val[idx] && (m_pc[idx][31:bidx_w+2] == pc[31:bidx_w+2]);
        if (r.btb_hit) begin
            r.pred_target = m_tgt[idx];
            r.pred_taken  = (m_kind[idx] == kind_jal) || (m_kind[idx] == kind_jalr) ||
                            (m_kind[idx] == kind_branch && m_pht[r.pht_idx][1]);
        end
        return r;
    endfunction

    // returns the mispredict flag and trains the model tables
    function automatic logic resolve_ref(input bp_rec_t r, input logic [31:0] ins,
                                         input logic tk, input logic [31:0] tgt,
                                         output logic [31:0] redir);
        logic [bidx_w-1:0] idx;
        bp_kind_e          k;
        logic              at;
        logic [31:0]       atgt;
        logic              mis;
        idx  = r.pc[bidx_w+1:2];
        k    = kind_none;
        at   = 1'b0;
        atgt = r.pc + 32'd4;
        if (ins[6:0] == opc_branch) begin
            k    = kind_branch;
            at   = tk;
            atgt = r.pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end else if (ins[6:0] == opc_jal) begin
            k    = kind_jal;
            at   = 1'b1;
            atgt = r.pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end else if (ins[6:0] == opc_jalr) begin
            k    = kind_jalr;
            at   = 1'b1;
            atgt = tgt;
        end
        mis   = (at != r.pred_taken) || (at && atgt != r.pred_target);
        redir = at ? atgt : r.pc + 32'd4;
        if (k != kind_none) begin
            m_pc[idx]   = r.pc;
            m_tgt[idx]  = atgt;
            m_kind[idx] = k;
            m_val[idx]  = 1'b1;
        end
        if (k == kind_branch) begin
            if (at && m_pht[r.pht_idx] != 2'b11) begin
                m_pht[r.pht_idx] = m_pht[r.pht_idx] + 2'b01;
            end else if (!at && m_pht[r.pht_idx] != 2'b00) begin
                m_pht[r.pht_idx] = m_pht[r.pht_idx] - 2'b01;
            end
            m_ghr = {m_ghr[gw-2:0], at};
        end
        return mis;
    endfunction

    task automatic check_bit(input string what, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            $display("ERR %s %s: expected %b, actual %b", test_name, what, exp, act);
            err_count++;
            test_err++;
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (act !== exp) begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
            err_count++;
            test_err++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("%s: %s", test_name, msg);
        err_count++;
        test_err++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err  = 0;
        test_count++;
    endtask

    task automatic end_test();
        $display("test %-12s %s, %0d errors", test_name, (test_err == 0) ? "ok" : "FAILED", test_err);
    endtask

    task automatic wait_fetch();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!fetch_hs && n < hs_limit);
        if (!fetch_hs) note_failure("fetch handshake did not complete in time");
    endtask

    task automatic wait_resolve();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!res_hs && n < hs_limit);
        if (!res_hs) note_failure("resolve handshake did not complete in time");
    endtask

    task automatic do_fetch(input logic [31:0] pc);
        @(posedge clk);
        fetch_valid_i <= 1'b1;
        fetch_pc_i    <= pc;
        wait_fetch();
        fetch_valid_i <= 1'b0;
    endtask

    task automatic do_resolve(input logic [31:0] ins, input logic tk, input logic [31:0] tgt);
        @(posedge clk);
        resolve_valid_i  <= 1'b1;
        resolve_instr_i  <= ins;
        resolve_taken_i  <= tk;
        resolve_target_i <= tgt;
        wait_resolve();
        resolve_valid_i <= 1'b0;
    endtask

    // compare process, steps the model for the coming edge after checking the current one
    initial begin
        bp_rec_t     p;
        logic        acc;
        logic        fire;
        logic        mis;
        logic [31:0] redir;
        forever begin
            @(negedge clk);
            if (arst_n_i) begin
                p = predict_ref(fetch_pc_i);
                check_bit("pred_taken", p.pred_taken, pred_taken_o);
                check_word("pred_target", p.pred_target, pred_target_o);
                check_bit("fetch_ready", mq.size() < depth, fetch_ready_o);
                check_bit("resolve_ready", mq.size() != 0, resolve_ready_o);
                check_bit("mispredict", exp_mis, mispredict_o);
                if (redir_known) check_word("redirect_pc", exp_redir, redirect_pc_o);
                acc      = fetch_valid_i && (mq.size() < depth);
                fire     = resolve_valid_i && (mq.size() != 0);
                fetch_hs = acc;
                res_hs   = fire;
                if (acc) begin
                    hs_taken  = pred_taken_o;
                    hs_target = pred_target_o;
                end
                mis = 1'b0;
                if (fire) begin
                    mis = resolve_ref(mq.pop_front(), resolve_instr_i, resolve_taken_i,
                                      resolve_target_i, redir);
                    exp_redir   = redir;
                    redir_known = 1'b1;
                end
                exp_mis = mis;
                if (mis) mq.delete();  // flush drops a same-cycle fetch too
                else if (acc) mq.push_back(p);
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(8));
        arst_n_i = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_pc_i = 32'd0;
        resolve_valid_i = 1'b0;
        resolve_instr_i = instr_addi;
        resolve_taken_i = 1'b0;
        resolve_target_i = 32'd0;
        exp_mis = 1'b0;
        exp_redir = 32'd0;
        redir_known = 1'b0;
        fetch_hs = 1'b0;
        res_hs = 1'b0;
        hs_taken = 1'b0;
        hs_target = 32'd0;
        fetch_done = 1'b0;
        test_count = 0;
        check_count = 0;
        err_count = 0;
        m_ghr = '0;
        for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
            m_val[i] = 1'b0;
        end
        for (int i = 0; i < (1 << gw); i++) begin
            m_pht[i] = 2'b01;
        end
        repeat (8) @(posedge clk);
        arst_n_i <= 1'b1;

        start_test("reset");
        @(posedge clk);
        fetch_pc_i <= 32'h0000_0abc;
        @(negedge clk);
        check_bit("fetch_ready", 1'b1, fetch_ready_o);
        check_bit("resolve_ready", 1'b0, resolve_ready_o);
        check_bit("mispredict", 1'b0, mispredict_o);
        check_bit("pred_taken", 1'b0, pred_taken_o);
        check_word("pred_target", 32'd0, pred_target_o);
        end_test();

        start_test("jal");
        do_fetch(32'h100);
        check_bit("first fetch taken", 1'b0, hs_taken);
        do_resolve(enc_j(32'h40), 1'b0, 32'd0);
        @(negedge clk);
        check_bit("first resolve mispredict", 1'b1, mispredict_o);
        check_word("first resolve redirect", 32'h140, redirect_pc_o);
        do_fetch(32'h100);
        check_bit("second fetch taken", 1'b1, hs_taken);
        check_word("second fetch target", 32'h140, hs_target);
        do_resolve(enc_j(32'h40), 1'b0, 32'd0);
        @(negedge clk);
        check_bit("second resolve mispredict", 1'b0, mispredict_o);
        end_test();

        // pc 0x300 has zero low index bits, so the pattern index is the history itself
        start_test("branch");
        for (int i = 0; i < 9; i++) begin
            do_fetch(32'h300);
            check_bit("loop pred taken", i >= 6, hs_taken);
            if (i >= 6) check_word("loop pred target", 32'h2e0, hs_target);
            do_resolve(enc_b(-32'sd32), 1'b1, 32'd0);
        end
        end_test();

        start_test("jalr");
        do_fetch(32'h444);
        do_resolve(instr_jalr, 1'b0, 32'h8000);
        @(negedge clk);
        check_bit("learn mispredict", 1'b1, mispredict_o);
        check_word("learn redirect", 32'h8000, redirect_pc_o);
        do_fetch(32'h444);
        check_bit("hit taken", 1'b1, hs_taken);
        check_word("hit target", 32'h8000, hs_target);
        do_resolve(instr_jalr, 1'b0, 32'h9000);
        @(negedge clk);
        check_bit("new target mispredict", 1'b1, mispredict_o);
        check_word("new target redirect", 32'h9000, redirect_pc_o);
        end_test();

        start_test("full_flush");
        for (int k = 0; k < depth; k++) begin
            do_fetch(32'h2000 + 32'(k * 4));
        end
        @(negedge clk);
        check_bit("full fetch_ready", 1'b0, fetch_ready_o);
        check_bit("full resolve_ready", 1'b1, resolve_ready_o);
        do_resolve(enc_j(32'h10), 1'b0, 32'd0);
        @(negedge clk);
        check_bit("flush mispredict", 1'b1, mispredict_o);
        check_bit("flush resolve_ready", 1'b0, resolve_ready_o);
        check_bit("flush fetch_ready", 1'b1, fetch_ready_o);
        end_test();

        start_test("random");
        fork
            begin : fetch_drv
                for (int c = 0; c < n_rand; c++) begin
                    @(posedge clk);
                    if (!fetch_valid_i || fetch_hs) begin
                        fetch_valid_i <= ($urandom % 4) != 0;
                        fetch_pc_i    <= 32'h1000 + (($urandom % 128) << 2);
                    end
                end
                @(posedge clk);
                if (fetch_valid_i && !fetch_hs) wait_fetch();
                fetch_valid_i <= 1'b0;
                fetch_done = 1'b1;
            end
            begin : resolve_drv
                int c;
                c = 0;
                while (!(fetch_done && mq.size() == 0) && c < n_rand * 4) begin
                    @(posedge clk);
                    c++;
                    if (!resolve_valid_i || res_hs) begin
                        resolve_valid_i  <= ($urandom % 3) != 0;
                        resolve_taken_i  <= 1'($urandom % 2);
                        resolve_target_i <= 32'h4000 + (($urandom % 4) << 4);
                    end
                    resolve_instr_i <= (mq.size() != 0) ? program_instr(mq[0].pc) : instr_addi;
                end
                if (mq.size() != 0) note_failure("random stream did not drain the queue");
                resolve_valid_i <= 1'b0;
            end
        join
        repeat (3) @(posedge clk);
        end_test();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
